//--- rtl/vc_geometry_pkg.sv
package vc_geometry_pkg;

	// ############################################################
	// victim cache geometry
	// ############################################################

	// number of fully associative victim entries
	localparam int vc_entries = 4;

	// one cache line
	localparam int line_bits = 128;

	// byte address as seen by the level-one cache
	localparam int addr_bits = 32;
	localparam int offset_bits = 4;

	// the line address doubles as the tag, nothing is indexed
	localparam int tag_bits = addr_bits - offset_bits;

	typedef logic [tag_bits-1:0] line_addr_t;
	typedef logic [line_bits-1:0] line_data_t;
	typedef logic [$clog2(vc_entries)-1:0] entry_index_t;

endpackage : vc_geometry_pkg

//--- rtl/vc_bus_pkg.sv
package vc_bus_pkg;

	// ############################################################
	// level-one side
	// ############################################################

	// held by the requester until resp is seen
	typedef struct packed {
		logic swap;
		logic read;
		vc_geometry_pkg::line_addr_t req_addr;
		// evicted line, only meaningful with swap
		vc_geometry_pkg::line_addr_t evict_addr;
		vc_geometry_pkg::line_data_t evict_data;
		logic evict_dirty;
	} l1_req_t;

	// data is only valid while resp is high
	typedef struct packed {
		logic resp;
		vc_geometry_pkg::line_data_t data;
	} l1_resp_t;

	// ############################################################
	// physical memory side
	// ############################################################

	// command held until pmem resp, read and write never together
	typedef struct packed {
		logic read;
		logic write;
		vc_geometry_pkg::line_addr_t addr;
		vc_geometry_pkg::line_data_t wdata;
	} pmem_req_t;

	typedef struct packed {
		logic resp;
		vc_geometry_pkg::line_data_t rdata;
	} pmem_resp_t;

endpackage : vc_bus_pkg

//--- rtl/victim_cache_control.sv
`timescale 1ns/1ps

module victim_cache_control
(
	input logic clk,
	input logic reset,

	// level-one request kind
	input logic swap,
	input logic read,

	// status from the datapath
	input logic tag_match,
	input logic valid,
	input logic dirty,

	// datapath load strobes
	output logic ld_data_reg,
	output logic ld_cache,
	output logic ld_from_vic,

	// back to the level-one cache
	output logic mem_resp,

	// physical memory handshake
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write
);

	typedef enum logic [1:0] {
		idle_check,
		phys_mem_write,
		phys_mem_read
	} state_t;

	state_t state;
	state_t next_state;

	// requested line sits in a valid entry
	logic hit;
	// round-robin entry must go back to memory before the fill
	logic victim_dirty;

	assign hit = tag_match && valid;
	assign victim_dirty = (~tag_match) && valid && dirty;

	// ############################################################
	// outputs per state
	// ############################################################

	always_comb
	begin : state_actions
		ld_data_reg = 1'b0;
		ld_cache = 1'b0;
		ld_from_vic = 1'b0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		case (state)
			idle_check:
			begin
				if (swap && hit)
				begin
					// lines trade places, answered in this cycle
					ld_from_vic = 1'b1;
					ld_cache = 1'b1;
					mem_resp = 1'b1;
				end
				else if (swap && victim_dirty)
				begin
					// park the dirty victim, then take its slot
					ld_data_reg = 1'b1;
					ld_cache = 1'b1;
				end
				else if (swap)
				begin
					// clean or empty slot is simply overwritten
					ld_cache = 1'b1;
				end
				else if (read && hit)
				begin
					// hand the line over, entry gets freed
					ld_from_vic = 1'b1;
					mem_resp = 1'b1;
				end
			end

			phys_mem_write:
			begin
				pmem_write = 1'b1;
			end

			phys_mem_read:
			begin
				pmem_read = 1'b1;
				// rdata goes straight through to the requester
				mem_resp = pmem_resp;
			end

			default:
			begin
				// nothing driven
			end
		endcase
	end

	// ############################################################
	// transitions
	// ############################################################

	always_comb
	begin : next_state_logic
		next_state = state;

		case (state)
			idle_check:
			begin
				if (swap && victim_dirty)
					next_state = phys_mem_write;
				else if (swap && !hit)
					next_state = phys_mem_read;
				else if (read && !hit)
					next_state = phys_mem_read;
			end

			phys_mem_write:
			begin
				if (pmem_resp)
					next_state = phys_mem_read;
			end

			phys_mem_read:
			begin
				if (pmem_resp)
					next_state = idle_check;
			end

			default:
			begin
				next_state = idle_check;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin : next_state_assignment
		if (reset)
			state <= idle_check;
		else
			state <= next_state;
	end

endmodule : victim_cache_control

//--- rtl/victim_cache_datapath.sv
`timescale 1ns/1ps

module victim_cache_datapath
(
	input logic clk,
	input logic reset,

	// level-one request, held for the whole transaction
	input vc_bus_pkg::l1_req_t l1_req,

	// strobes from the control
	input logic ld_cache,
	input logic ld_from_vic,
	input logic ld_data_reg,
	input logic pmem_read,
	input logic pmem_write,

	// status to the control
	output logic tag_match,
	output logic valid,
	output logic dirty,

	// response data to the level-one cache
	output vc_geometry_pkg::line_data_t resp_data,

	// physical memory command payload
	input vc_geometry_pkg::line_data_t pmem_rdata,
	output vc_geometry_pkg::line_addr_t pmem_addr,
	output vc_geometry_pkg::line_data_t pmem_wdata
);

	// payload of one victim entry
	typedef struct packed {
		logic dirty;
		vc_geometry_pkg::line_addr_t tag;
		vc_geometry_pkg::line_data_t data;
	} vc_entry_t;

	vc_entry_t entries [vc_geometry_pkg::vc_entries];
	logic valid_q [vc_geometry_pkg::vc_entries];

	// round-robin replacement pointer
	vc_geometry_pkg::entry_index_t ptr;
	vc_geometry_pkg::entry_index_t next_ptr;

	// write-back buffer for a displaced dirty line
	vc_geometry_pkg::line_addr_t wb_addr;
	vc_geometry_pkg::line_data_t wb_data;

	vc_geometry_pkg::entry_index_t match_idx;
	// entry the evicted line goes into
	vc_geometry_pkg::entry_index_t fill_idx;

	// ############################################################
	// lookup
	// ############################################################

	// only valid entries take part, a freed entry never matches
	always_comb
	begin : tag_compare
		tag_match = 1'b0;
		match_idx = '0;
		for (int i = 0; i < vc_geometry_pkg::vc_entries; i++)
		begin
			if (valid_q[i] && (entries[i].tag == l1_req.req_addr))
			begin
				tag_match = 1'b1;
				match_idx = vc_geometry_pkg::entry_index_t'(i);
			end
		end
	end

	// a hit reuses its own slot, a miss takes the pointer slot
	assign fill_idx = tag_match ? match_idx : ptr;

	assign valid = valid_q[fill_idx];
	assign dirty = entries[ptr].dirty;

	assign next_ptr = (ptr == vc_geometry_pkg::entry_index_t'(vc_geometry_pkg::vc_entries - 1))
		? '0 : ptr + 1'b1;

	// ############################################################
	// entry array and write-back buffer
	// ############################################################

	always_ff @(posedge clk)
	begin : payload_update
		// buffer samples the old pointer entry before it is overwritten
		if (ld_data_reg)
		begin
			wb_addr <= entries[ptr].tag;
			wb_data <= entries[ptr].data;
		end
		if (ld_cache)
		begin
			entries[fill_idx].tag <= l1_req.evict_addr;
			entries[fill_idx].data <= l1_req.evict_data;
			entries[fill_idx].dirty <= l1_req.evict_dirty;
		end
	end

	always_ff @(posedge clk)
	begin : control_update
		if (reset)
		begin
			for (int i = 0; i < vc_geometry_pkg::vc_entries; i++)
				valid_q[i] <= 1'b0;
			ptr <= '0;
		end
		else if (ld_cache)
		begin
			valid_q[fill_idx] <= 1'b1;
			// pointer only moves when a new slot was consumed
			if (!tag_match)
				ptr <= next_ptr;
		end
		else if (ld_from_vic)
		begin
			// read hit, line now lives in the level-one cache
			valid_q[match_idx] <= 1'b0;
		end
	end

	// ############################################################
	// steering
	// ############################################################

	assign pmem_addr = pmem_write ? wb_addr : l1_req.req_addr;
	assign pmem_wdata = wb_data;

	// hit data comes from the entry before the swap edge
	// data bus stays quiet outside a hit or a fill
	assign resp_data = ld_from_vic ? entries[match_idx].data
		: (pmem_read ? pmem_rdata : '0);

endmodule : victim_cache_datapath

//--- rtl/victim_cache.sv
`timescale 1ns/1ps

module victim_cache
(
	input logic clk,
	input logic reset,

	// level-one port
	input vc_bus_pkg::l1_req_t l1_req,
	output vc_bus_pkg::l1_resp_t l1_resp,

	// physical memory port
	output vc_bus_pkg::pmem_req_t pmem_req,
	input vc_bus_pkg::pmem_resp_t pmem_resp
);

	// status, datapath to control
	logic tag_match;
	logic valid;
	logic dirty;

	// strobes, control to datapath
	logic ld_cache;
	logic ld_from_vic;
	logic ld_data_reg;
	logic pmem_read;
	logic pmem_write;
	logic mem_resp;

	vc_geometry_pkg::line_data_t resp_data;
	vc_geometry_pkg::line_addr_t pmem_addr;
	vc_geometry_pkg::line_data_t pmem_wdata;

	// ############################################################
	// port packing
	// ############################################################

	assign l1_resp.resp = mem_resp;
	assign l1_resp.data = resp_data;

	assign pmem_req.read = pmem_read;
	assign pmem_req.write = pmem_write;
	assign pmem_req.addr = pmem_addr;
	assign pmem_req.wdata = pmem_wdata;

	victim_cache_control control_inst
	(
		.clk (clk),
		.reset (reset),
		.swap (l1_req.swap),
		.read (l1_req.read),
		.tag_match (tag_match),
		.valid (valid),
		.dirty (dirty),
		.ld_data_reg (ld_data_reg),
		.ld_cache (ld_cache),
		.ld_from_vic (ld_from_vic),
		.mem_resp (mem_resp),
		.pmem_resp (pmem_resp.resp),
		.pmem_read (pmem_read),
		.pmem_write (pmem_write)
	);

	victim_cache_datapath datapath_inst
	(
		.clk (clk),
		.reset (reset),
		.l1_req (l1_req),
		.ld_cache (ld_cache),
		.ld_from_vic (ld_from_vic),
		.ld_data_reg (ld_data_reg),
		.pmem_read (pmem_read),
		.pmem_write (pmem_write),
		.tag_match (tag_match),
		.valid (valid),
		.dirty (dirty),
		.resp_data (resp_data),
		.pmem_rdata (pmem_resp.rdata),
		.pmem_addr (pmem_addr),
		.pmem_wdata (pmem_wdata)
	);

endmodule : victim_cache

//--- testbench/pmem_model.sv
`timescale 1ns/1ps

module pmem_model
(
	input logic clk,
	input logic reset,
	input vc_bus_pkg::pmem_req_t pmem_req,
	output vc_bus_pkg::pmem_resp_t pmem_resp
);

	// only 16 test lines, indexed by the low address bits
	vc_geometry_pkg::line_data_t mem [16];
	logic written [16];
	logic busy;
	logic [2:0] left;
	integer seed = 32'h599b_30ba;

	// untouched line reads as its own line address, repeated
	function automatic vc_geometry_pkg::line_data_t line_pattern(
		vc_geometry_pkg::line_addr_t a);
		return {4{4'h0, a}};
	endfunction

	always @(posedge clk)
	begin : respond
		if (reset)
		begin
			pmem_resp <= '0;
			busy <= 1'b0;
			left <= '0;
			for (int i = 0; i < 16; i++)
				written[i] <= 1'b0;
		end
		else if (pmem_resp.resp)
		begin
			// one cycle pulse, next command starts fresh
			pmem_resp.resp <= 1'b0;
		end
		else if (pmem_req.read || pmem_req.write)
		begin
			if (!busy)
			begin
				busy <= 1'b1;
				// latency 1 to 4 cycles
				left <= 3'(1 + ($unsigned($random(seed)) % 4));
			end
			else if (left == 3'd1)
			begin
				busy <= 1'b0;
				pmem_resp.resp <= 1'b1;
				if (pmem_req.write)
				begin
					mem[pmem_req.addr[3:0]] <= pmem_req.wdata;
					written[pmem_req.addr[3:0]] <= 1'b1;
				end
				pmem_resp.rdata <= written[pmem_req.addr[3:0]] ? mem[pmem_req.addr[3:0]]
					: line_pattern(pmem_req.addr);
			end
			else
				left <= left - 3'd1;
		end
	end

endmodule : pmem_model

//--- testbench/victim_cache_chk.sv
`timescale 1ns/1ps

module victim_cache_chk
(
	input logic clk,
	input logic reset,
	input logic [1:0] state,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write
);

	// memory bus carries one command at a time
	read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(pmem_read && pmem_write))
		else $error("pmem read and write high together");

	// write-back never answers the level-one cache (state 1 is the write state)
	no_resp_in_write: assert property (@(posedge clk) disable iff (reset)
		(state == 2'd1) |-> !mem_resp)
		else $error("mem_resp high in write state");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !(mem_resp || pmem_read || pmem_write))
		else $error("outputs active after reset");

endmodule : victim_cache_chk

bind victim_cache_control victim_cache_chk chk_inst
(
	.clk (clk),
	.reset (reset),
	.state (state),
	.mem_resp (mem_resp),
	.pmem_read (pmem_read),
	.pmem_write (pmem_write)
);

//--- testbench/victim_cache_scoreboard.sv
`timescale 1ns/1ps

module victim_cache_scoreboard
(
	input logic clk,
	input logic reset,
	input vc_bus_pkg::l1_req_t l1_req,
	input vc_bus_pkg::l1_resp_t l1_resp,
	input vc_bus_pkg::pmem_req_t pmem_req,
	input vc_bus_pkg::pmem_resp_t pmem_resp,
	// expectations of the current table row
	input string test_name,
	input logic exp_hit,
	// line written back before the read, zero when none
	input vc_geometry_pkg::line_addr_t exp_wb
);

	// last evicted data of each test line, else the initial pattern
	vc_geometry_pkg::line_data_t shadow [16];
	int errors;
	int cycles;
	int writes;
	logic saw_read;

	function automatic vc_geometry_pkg::line_data_t line_pattern(
		vc_geometry_pkg::line_addr_t a);
		return {4{4'h0, a}};
	endfunction

	initial
	begin
		for (int i = 0; i < 16; i++)
			shadow[i] = line_pattern(28'h100 + 28'(i));
		errors = 0;
		cycles = 0;
		writes = 0;
		saw_read = 1'b0;
	end

	// ############################################################
	// per-cycle monitor
	// ############################################################

	always @(posedge clk)
	begin : monitor
		int cyc;
		int exp_writes;
		cyc = cycles + 1;
		exp_writes = (exp_wb != '0) ? 1 : 0;
		if (!reset && (l1_req.swap || l1_req.read))
		begin
			cycles = cyc;
			if (pmem_req.read)
				saw_read = 1'b1;
			if (pmem_req.write && pmem_resp.resp)
			begin
				writes = writes + 1;
				if (saw_read)
				begin
					$display("%s: write-back came after the read", test_name);
					errors = errors + 1;
				end
				if (pmem_req.addr !== exp_wb)
				begin
					$display("mismatch %s wb addr: expected %h actual %h", test_name,
						exp_wb, pmem_req.addr);
					errors = errors + 1;
				end
				if (pmem_req.wdata !== shadow[exp_wb[3:0]])
				begin
					$display("mismatch %s wdata: expected %h actual %h", test_name,
						shadow[exp_wb[3:0]], pmem_req.wdata);
					errors = errors + 1;
				end
			end
			// the fill always fetches the requested line
			if (pmem_req.read && pmem_resp.resp && (pmem_req.addr !== l1_req.req_addr))
			begin
				$display("mismatch %s read addr: expected %h actual %h", test_name,
					l1_req.req_addr, pmem_req.addr);
				errors = errors + 1;
			end
			if (l1_resp.resp)
			begin
				if (l1_resp.data !== shadow[l1_req.req_addr[3:0]])
				begin
					$display("mismatch %s data: expected %h actual %h", test_name,
						shadow[l1_req.req_addr[3:0]], l1_resp.data);
					errors = errors + 1;
				end
				// a hit answers in the first cycle
				if (exp_hit != (cyc == 1))
				begin
					$display("mismatch %s hit: expected %0d actual %0d", test_name,
						exp_hit, (cyc == 1));
					errors = errors + 1;
				end
				if (exp_hit && saw_read)
				begin
					$display("%s: memory read on a hit", test_name);
					errors = errors + 1;
				end
				if (!exp_hit && !saw_read)
				begin
					$display("%s: miss answered without a memory read", test_name);
					errors = errors + 1;
				end
				if (writes != exp_writes)
				begin
					$display("mismatch %s write-backs: expected %0d actual %0d", test_name,
						exp_writes, writes);
					errors = errors + 1;
				end
				// evicted line now holds the newest copy
				if (l1_req.swap)
					shadow[l1_req.evict_addr[3:0]] = l1_req.evict_data;
				cycles = 0;
				writes = 0;
				saw_read = 1'b0;
			end
		end
		else if (!reset && (l1_resp.resp || pmem_req.read || pmem_req.write))
		begin
			$display("DUT active while no request is pending");
			errors = errors + 1;
		end
	end

endmodule : victim_cache_scoreboard

//--- testbench/victim_cache_tb.sv
`timescale 1ns/1ps

module victim_cache_tb;

	localparam int rows = 16;

	typedef struct {
		string name;
		logic is_swap;
		vc_geometry_pkg::line_addr_t req;
		vc_geometry_pkg::line_addr_t evict;
		logic dirty;
		logic hit;
		// line written back before the read, zero when none
		vc_geometry_pkg::line_addr_t wb;
	} row_t;

	logic clk;
	logic reset;
	vc_bus_pkg::l1_req_t l1_req;
	vc_bus_pkg::l1_resp_t l1_resp;
	vc_bus_pkg::pmem_req_t pmem_req;
	vc_bus_pkg::pmem_resp_t pmem_resp;
	string test_name;
	logic exp_hit;
	vc_geometry_pkg::line_addr_t exp_wb;
	row_t table_rows [rows];
	integer seed = 32'h599b_30ba;

	victim_cache victim_cache_inst (.*);
	pmem_model pmem_inst (.*);
	victim_cache_scoreboard scoreboard_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// worst case is about 12 cycles a row, doubled for margin
	initial
	begin : watchdog
		#(rows * 12 * 20 * 2 + 10 * 20);
		$display("timeout, a request was never answered");
		$display("Result: FAILED");
		$finish;
	end

	// ############################################################
	// stimulus table with name, swap, req, evict, dirty, hit and write-back line
	// ############################################################

	initial
	begin : stimulus
		vc_bus_pkg::l1_req_t req;
		table_rows[0] = '{"read_cold", 0, 28'h100, 28'h000, 0, 0, 28'h000};
		table_rows[1] = '{"swap_fill0", 1, 28'h101, 28'h102, 1, 0, 28'h000};
		table_rows[2] = '{"swap_fill1", 1, 28'h103, 28'h104, 0, 0, 28'h000};
		table_rows[3] = '{"swap_fill2", 1, 28'h105, 28'h106, 1, 0, 28'h000};
		table_rows[4] = '{"swap_hit", 1, 28'h102, 28'h107, 0, 1, 28'h000};
		table_rows[5] = '{"read_hit", 0, 28'h104, 28'h000, 0, 1, 28'h000};
		table_rows[6] = '{"read_after_hit", 0, 28'h104, 28'h000, 0, 0, 28'h000};
		table_rows[7] = '{"swap_fill3", 1, 28'h108, 28'h109, 1, 0, 28'h000};
		table_rows[8] = '{"swap_clean_victim", 1, 28'h10a, 28'h10b, 1, 0, 28'h000};
		table_rows[9] = '{"swap_empty_slot", 1, 28'h10c, 28'h10d, 0, 0, 28'h000};
		table_rows[10] = '{"swap_dirty_wb", 1, 28'h10e, 28'h10f, 0, 0, 28'h106};
		table_rows[11] = '{"read_wb_line", 0, 28'h106, 28'h000, 0, 0, 28'h000};
		table_rows[12] = '{"read_no_fill", 0, 28'h106, 28'h000, 0, 0, 28'h000};
		table_rows[13] = '{"swap_dirty_wb2", 1, 28'h100, 28'h105, 0, 0, 28'h109};
		table_rows[14] = '{"swap_hit_dirty", 1, 28'h10b, 28'h101, 1, 1, 28'h000};
		table_rows[15] = '{"read_hit_dirty", 0, 28'h101, 28'h000, 0, 1, 28'h000};

		reset <= 1'b1;
		l1_req <= '0;
		test_name <= "reset";
		exp_hit <= 1'b0;
		exp_wb <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// short idle gap in which the scoreboard flags any stray activity
		repeat (3) @(posedge clk);

		for (int i = 0; i < rows; i++)
		begin
			@(posedge clk);
			req = '0;
			req.swap = table_rows[i].is_swap;
			req.read = !table_rows[i].is_swap;
			req.req_addr = table_rows[i].req;
			req.evict_addr = table_rows[i].evict;
			req.evict_dirty = table_rows[i].dirty;
			// dirty lines get fresh data, clean ones repeat the shadow copy
			if (table_rows[i].dirty)
				req.evict_data = {32'($random(seed)), 32'($random(seed)),
					32'($random(seed)), 32'($random(seed))};
			else
				req.evict_data = scoreboard_inst.shadow[table_rows[i].evict[3:0]];
			l1_req <= req;
			test_name <= table_rows[i].name;
			exp_hit <= table_rows[i].hit;
			exp_wb <= table_rows[i].wb;
			@(negedge clk);
			while (!l1_resp.resp)
				@(negedge clk);
			@(posedge clk);
			l1_req <= '0;
		end

		repeat (3) @(posedge clk);
		$display("errors: %0d", scoreboard_inst.errors);
		if (scoreboard_inst.errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule : victim_cache_tb

//--- victim_cache.f
rtl/vc_geometry_pkg.sv
rtl/vc_bus_pkg.sv
rtl/victim_cache_control.sv
rtl/victim_cache_datapath.sv
rtl/victim_cache.sv
testbench/pmem_model.sv
testbench/victim_cache_chk.sv
testbench/victim_cache_scoreboard.sv
testbench/victim_cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= victim_cache_tb
FILELIST ?= victim_cache.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
